// ==== all.f ====
src/zbus_pkg.sv
src/pager_cfg_pkg.sv
src/port_regs.sv
src/window_pager.sv
src/dos_ctrl.sv
src/mem_pager_top.sv
tb/mem_pager_asserts.sv
tb/mem_pager_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the pager testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module mem_pager_tb \
	-f all.f \
	-o mem_pager_sim

./obj_dir/mem_pager_sim | tee sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// ==== tb/mem_pager_tb.sv ====
`timescale 1ns/1ps

module mem_pager_tb;

	localparam int N_OPS       = 400;                   // random operations
	localparam int OP_CYCLES   = 24;                    // cycle budget of one operation
	localparam int STIM_CYCLES = (N_OPS + 60) * OP_CYCLES; // directed part counted as 60 ops
	localparam int MAX_CYCLES  = 4 * STIM_CYCLES + 200;

	logic                    fclk;
	logic                    reset;
	logic                    s3;
	logic                    zpos;
	logic                    zneg;
	logic                    pager_off;
	logic                    in_nmi;
	zbus_pkg::zbus_t         zbus;
	pager_cfg_pkg::mem_map_t map [pager_cfg_pkg::NUM_WIN];
	logic [7:0]              rd_be;
	logic                    dos;
	logic                    zclk_stall;

	pager_cfg_pkg::win_cfg_t   m_cfg [pager_cfg_pkg::NUM_WIN]; // model registers
	pager_cfg_pkg::pent_mode_t m_mode;
	pager_cfg_pkg::mem_map_t   m_map [pager_cfg_pkg::NUM_WIN];
	logic                      m_dos;
	logic [1:0]                m_stall;  // enabled edges of stall left
	logic                      m_m1_q;
	logic                      m_mreq_q;
	int                        en_cnt;
	int                        checked_cnt;
	int                        errors;
	int                        cycles;
	logic [31:0]               rng;
	logic                      phase;    // next enabled cycle is zpos when set
	logic                      got_neg;  // last cycle was an enabled zneg
	logic                      got_pos;
	logic                      po_req;
	logic                      nmi_req;

	mem_pager_top dut_i
	(
		.fclk       (fclk),
		.reset      (reset),
		.s3         (s3),
		.zpos       (zpos),
		.zneg       (zneg),
		.pager_off  (pager_off),
		.in_nmi     (in_nmi),
		.zbus       (zbus),
		.map        (map),
		.rd_be      (rd_be),
		.dos        (dos),
		.zclk_stall (zclk_stall)
	);

	initial fclk = 1'b0;
	always #4 fclk = ~fclk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic zbus_pkg::zbus_t idle_bus(input logic [15:0] a);
		zbus_pkg::zbus_t b;
		b = '1; // all strobes released
		b.addr = a;
		return b;
	endfunction

	// expected map of one window, from the settings before the edge
	function automatic pager_cfg_pkg::mem_map_t ref_map(input int w,
		input pager_cfg_pkg::win_cfg_t c, input pager_cfg_pkg::pent_mode_t md,
		input logic po, input logic nmi, input logic d);
		pager_cfg_pkg::mem_map_t r;
		logic [7:0]              pg;
		logic                    rs;
		rs = md.rom_sel;
		pg = rs ? c.page1 : c.page0;
		r.romnram = ~c.ramnrom[rs];
		r.page = pg;
		if (c.dos7ffd[rs] && c.ramnrom[rs])
			r.page = md.mb_on ? {pg[7:6], md.page} : {pg[7:3], md.page[2:0]};
		else if (c.dos7ffd[rs])
			r.page = {pg[7:1], d}; // rom half follows dos
		if (w == 0 && md.ram0_0)
			r = '{romnram: 1'b0, page: 8'h00};
		if (w == 0 && nmi)
			r = '{romnram: 1'b0, page: pager_cfg_pkg::NMI_PAGE};
		if (po)
			r = '{romnram: 1'b1, page: 8'hFF}; // highest priority last
		return r;
	endfunction

	function automatic logic [7:0] ref_rd_be(input logic [15:0] a);
		pager_cfg_pkg::win_cfg_t c;
		c = m_cfg[a[15:14]];
		case (a[13:12])
			2'b00:   return c.page0;
			2'b01:   return c.page1;
			2'b10:   return {4'h0, c.dos7ffd, c.ramnrom};
			default: return 8'h00;
		endcase
	endfunction

	// {turn_on, turn_off} for the bus in the current cycle
	function automatic logic [1:0] turn_reqs(input zbus_pkg::zbus_t b, input logic en,
		input logic neg);
		logic fetch;
		logic rs;
		int   w;
		rs = m_mode.rom_sel;
		w = int'(b.addr[15:14]);
		fetch = en & neg & ~b.mreq_n & m_mreq_q & ~m_m1_q;
		if (!fetch)
			return 2'b00;
		return {(b.addr[13:8] == zbus_pkg::DOS_TRAP_HI) & m_cfg[w].dos7ffd[1]
			& ~m_cfg[w].ramnrom[1] & rs, m_cfg[w].ramnrom[rs]};
	endfunction

	// reference model, steps on the same enabled edges as the dut
	always @(posedge fclk)
	begin : model_step
		pager_cfg_pkg::mem_map_t nm [pager_cfg_pkg::NUM_WIN];
		logic [1:0]              tr;
		logic                    io_wr;
		logic                    rs;
		int                      w;
		if (reset)
		begin
			for (int i = 0; i < pager_cfg_pkg::NUM_WIN; i++)
			begin
				m_cfg[i] = '0;
				m_map[i] = '{romnram: 1'b1, page: pager_cfg_pkg::RESET_PAGE};
			end
			m_mode = '0;
			m_dos = 1'b1;
			m_stall = 2'd0;
			m_m1_q = 1'b1;
			m_mreq_q = 1'b1;
		end
		else if (s3)
		begin
			tr = turn_reqs(zbus, s3, zneg);
			for (int i = 0; i < pager_cfg_pkg::NUM_WIN; i++)
				nm[i] = ref_map(i, m_cfg[i], m_mode, pager_off, in_nmi, m_dos);
			if (tr[1])
				m_dos = 1'b1;
			else if (tr[0])
				m_dos = 1'b0;
			if (tr[1])
				m_stall = 2'd3;
			else if (m_stall != 2'd0)
				m_stall = m_stall - 2'd1;
			io_wr = zneg & ~zbus.iorq_n & ~zbus.wr_n;
			rs = m_mode.rom_sel; // old set, before a 7FFD write lands
			w = int'(zbus.addr[15:14]);
			if (io_wr && zbus.addr[7:0] == zbus_pkg::PORT_F7_LO)
			begin
				if (zbus.addr[11])
				begin
					if (rs)
						m_cfg[w].page1 = ~{2'b11, zbus.data[5:0]};
					else
						m_cfg[w].page0 = ~{2'b11, zbus.data[5:0]};
					m_cfg[w].ramnrom[rs] = zbus.data[6];
					m_cfg[w].dos7ffd[rs] = zbus.data[7];
				end
				else
				begin
					if (rs)
						m_cfg[w].page1 = ~zbus.data;
					else
						m_cfg[w].page0 = ~zbus.data;
					m_cfg[w].ramnrom[rs] = 1'b1; // 4 MB form is always ram
				end
			end
			if (io_wr && !zbus.addr[15] && !zbus.addr[1])
			begin
				m_mode.rom_sel = zbus.data[4];
				m_mode.page = {zbus.data[7:5], zbus.data[2:0]};
			end
			if (io_wr && zbus.addr == zbus_pkg::PORT_EFF7)
			begin
				m_mode.ram0_0 = zbus.data[3];
				m_mode.mb_on = ~zbus.data[2];
			end
			if (zpos)
				m_m1_q = zbus.m1_n;
			if (zneg)
				m_mreq_q = zbus.mreq_n;
			for (int i = 0; i < pager_cfg_pkg::NUM_WIN; i++)
				m_map[i] = nm[i];
			en_cnt++;
		end
	end

	// compare at the falling edge, every second enabled edge
	always @(negedge fclk)
	begin : compare
		logic [1:0] tr;
		logic       exp_stall;
		if (!reset && en_cnt != checked_cnt && (en_cnt % 2) == 0)
		begin
			checked_cnt = en_cnt;
			tr = turn_reqs(zbus, s3, zneg);
			exp_stall = tr[1] | (m_stall != 2'd0);
			for (int i = 0; i < pager_cfg_pkg::NUM_WIN; i++)
				assert (map[i] == m_map[i]) else
				begin
					errors++;
					$display("mismatch at %0t: map[%0d] expected %h actual %h",
						$time, i, m_map[i], map[i]);
				end
			assert (rd_be == ref_rd_be(zbus.addr)) else
			begin
				errors++;
				$display("mismatch at %0t: rd_be expected %h actual %h",
					$time, ref_rd_be(zbus.addr), rd_be);
			end
			assert (dos == m_dos) else
			begin
				errors++;
				$display("mismatch at %0t: dos expected %b actual %b", $time, m_dos, dos);
			end
			assert (zclk_stall == exp_stall) else
			begin
				errors++;
				$display("mismatch at %0t: zclk_stall expected %b actual %b",
					$time, exp_stall, zclk_stall);
			end
		end
	end

	always @(posedge fclk)
	begin
		cycles++;
		if (cycles > MAX_CYCLES)
		begin
			$display("timeout: stimulus still running after %0d cycles", MAX_CYCLES);
			$display("** FAIL **");
			$finish;
		end
	end

	// one clock of stimulus, s3 at about 75 %
	task automatic tick(input zbus_pkg::zbus_t b);
		@(posedge fclk);
		got_neg = s3 & zneg; // cycle that just ended
		got_pos = s3 & zpos;
		rng = xorshift(rng);
		zbus <= b;
		pager_off <= po_req;
		in_nmi <= nmi_req;
		if (rng[1:0] != 2'b00)
		begin
			s3 <= 1'b1;
			zpos <= phase;
			zneg <= ~phase;
			phase = ~phase;
		end
		else
		begin
			s3 <= 1'b0;
			zpos <= 1'b0;
			zneg <= 1'b0;
		end
	endtask

	// hold the bus until an enabled zneg (or zpos) has seen it
	task automatic hold_until(input zbus_pkg::zbus_t b, input logic want_neg);
		logic hit;
		hit = 1'b0;
		tick(b);
		while (!hit)
		begin
			tick(b);
			hit = want_neg ? got_neg : got_pos;
		end
	endtask

	task automatic settle();
		hold_until(idle_bus(zbus.addr), 1'b0); // m1 high seen at zpos
		hold_until(idle_bus(zbus.addr), 1'b1); // mreq high seen at zneg
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		zbus_pkg::zbus_t b;
		b = idle_bus(a);
		b.data = d;
		b.iorq_n = 1'b0;
		b.wr_n = 1'b0;
		hold_until(b, 1'b1);
		settle();
	endtask

	task automatic f7_write(input logic [1:0] w, input logic mb1, input logic [7:0] d);
		io_write({w, rng[13:12], mb1, rng[10:8], zbus_pkg::PORT_F7_LO}, d);
	endtask

	task automatic readback(input logic [1:0] w, input logic [1:0] sel);
		zbus_pkg::zbus_t b;
		b = idle_bus({w, sel, rng[11:8], zbus_pkg::PORT_BE_LO});
		b.iorq_n = 1'b0;
		b.rd_n = 1'b0;
		repeat (6) tick(b);
	endtask

	// kind 0 normal fetch, 1 with m1 high, 2 with mreq low throughout
	task automatic fetch(input logic [15:0] a, input int kind);
		zbus_pkg::zbus_t b;
		b = idle_bus(a);
		b.m1_n = (kind != 0); // kind 2 keeps m1 high until mreq low is stored
		b.mreq_n = (kind != 2);
		hold_until(b, 1'b1);
		b.m1_n = (kind == 1);
		hold_until(b, 1'b0); // m1 stored
		b.mreq_n = 1'b0;
		b.rd_n = 1'b0;
		hold_until(b, 1'b1); // strobe edge for kind 0
		repeat (6) tick(b);  // stall window
		settle();
	endtask

	initial
	begin : stimulus
		logic [1:0] w;
		rng = 32'h2bc4_9d4e;
		phase = 1'b1;
		errors = 0;
		cycles = 0;
		en_cnt = 0;
		checked_cnt = 0;
		po_req = 1'b0;
		nmi_req = 1'b0;
		reset <= 1'b1;
		s3 <= 1'b0;
		zpos <= 1'b0;
		zneg <= 1'b0;
		pager_off <= 1'b0;
		in_nmi <= 1'b0;
		zbus <= idle_bus(16'h0000);
		repeat (4) tick(idle_bus(16'h0000));
		reset <= 1'b0;
		for (int i = 0; i < 4; i++) // reset readback
			for (int s = 0; s < 3; s++)
				readback(2'(i), 2'(s));
		io_write(16'h7FFD, 8'h10);          // rom_sel 1
		f7_write(2'd0, 1'b1, 8'h83);        // window 0 dos rom, dos7ffd set
		f7_write(2'd1, 1'b0, 8'h05);        // window 1 ram, 4 MB form
		f7_write(2'd1, 1'b0, 8'hA0);
		fetch(16'h4123, 0);                 // ram fetch leaves dos
		fetch(16'h3D2F, 1);                 // no m1, nothing happens
		fetch(16'h3D2F, 2);                 // no mreq edge, nothing happens
		fetch(16'h3D2F, 0);                 // dos entry with stall
		fetch(16'h3E00, 0);
		f7_write(2'd2, 1'b1, 8'hC9);        // window 2 ram with 7FFD paging
		io_write(16'h7FFD, 8'hF7);
		io_write(zbus_pkg::PORT_EFF7, 8'h00); // mb_on
		io_write(16'h7FFD, 8'hB5);
		f7_write(2'd3, 1'b1, 8'h9E);        // rom with dos bit in window 3
		readback(2'd3, 2'd2);
		po_req = 1'b1;
		nmi_req = 1'b1;
		settle();
		po_req = 1'b0;
		settle();
		io_write(zbus_pkg::PORT_EFF7, 8'h08); // ram0_0
		nmi_req = 1'b0;
		settle();
		io_write(zbus_pkg::PORT_EFF7, 8'h04);
		for (int n = 0; n < N_OPS; n++)
		begin
			rng = xorshift(rng);
			w = rng[9:8];
			case (rng[2:0])
				3'd0, 3'd1: f7_write(w, rng[3], rng[23:16]);
				3'd2:       io_write(16'h7FFD, rng[23:16]);
				3'd3:       io_write(zbus_pkg::PORT_EFF7, rng[23:16]);
				3'd4:       readback(w, rng[5:4] == 2'b11 ? 2'b10 : rng[5:4]);
				3'd5:       fetch({w, rng[4] ? 6'h3D : rng[21:16], rng[31:24]},
				                int'(rng[6:5]) % 3);
				3'd6:
				begin
					po_req = (rng[12:11] == 2'b00);
					nmi_req = (rng[14:13] == 2'b00);
					settle();
				end
				default:    repeat (int'(rng[13:11]) + 1) tick(idle_bus(zbus.addr));
			endcase
		end
		settle();
		$display("errors: %0d, enabled edges: %0d", errors, en_cnt);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== tb/mem_pager_asserts.sv ====
`timescale 1ns/1ps

module mem_pager_asserts
(
	input logic fclk,
	input logic reset,
	input logic s3,
	input logic zneg,
	input logic fetch_stb,
	input logic dos,
	input logic dos_turn_on,
	input logic zclk_stall
);

	logic [1:0] stall_left; // enabled edges of stall still owed

	always_ff @(posedge fclk)
	begin
		if (reset)
			stall_left <= 2'd0;
		else if (s3)
		begin
			if (dos_turn_on)
				stall_left <= 2'd3; // turn-on cycle plus three more edges
			else if (stall_left != 2'd0)
				stall_left <= stall_left - 2'd1;
		end
	end

	stall_held: assert property (@(posedge fclk) disable iff (reset)
		(stall_left != 2'd0) |-> zclk_stall)
		else $error("zclk_stall dropped before four enabled edges passed");

	stall_ends: assert property (@(posedge fclk) disable iff (reset)
		(stall_left == 2'd0 && !dos_turn_on) |-> !zclk_stall)
		else $error("zclk_stall high without a pending turn-on");

	fetch_on_zneg: assert property (@(posedge fclk) fetch_stb |-> zneg)
		else $error("fetch_stb seen while zneg was low");

	dos_hold: assert property (@(posedge fclk) disable iff (reset)
		!s3 |=> $stable(dos))
		else $error("dos changed on a disabled cycle");

endmodule

bind dos_ctrl mem_pager_asserts u_asserts
(
	.fclk        (fclk),
	.reset       (reset),
	.s3          (s3),
	.zneg        (zneg),
	.fetch_stb   (fetch_stb),
	.dos         (dos),
	.dos_turn_on (dos_turn_on),
	.zclk_stall  (zclk_stall)
);

// ==== src/mem_pager_top.sv ====
`timescale 1ns/1ps

module mem_pager_top
(
	input  logic                    fclk,
	input  logic                    reset,
	input  logic                    s3,
	input  logic                    zpos,
	input  logic                    zneg,
	input  logic                    pager_off,
	input  logic                    in_nmi,
	input  zbus_pkg::zbus_t         zbus,
	output pager_cfg_pkg::mem_map_t map [pager_cfg_pkg::NUM_WIN],
	output logic [7:0]              rd_be,
	output logic                    dos,
	output logic                    zclk_stall
);

	logic                              f7_wr;
	logic                              fetch_stb;
	logic [pager_cfg_pkg::NUM_WIN-1:0] dos_req;
	logic [pager_cfg_pkg::NUM_WIN-1:0] ram_req;
	pager_cfg_pkg::pent_mode_t         pent_mode;
	pager_cfg_pkg::win_cfg_t           cfg [pager_cfg_pkg::NUM_WIN];

	dos_ctrl u_dos_ctrl
	(
		.fclk       (fclk),
		.reset      (reset),
		.s3         (s3),
		.zpos       (zpos),
		.zneg       (zneg),
		.zbus       (zbus),
		.dos_req    (dos_req),
		.ram_req    (ram_req),
		.fetch_stb  (fetch_stb),
		.dos        (dos),
		.zclk_stall (zclk_stall)
	);

	port_regs u_port_regs
	(
		.fclk      (fclk),
		.reset     (reset),
		.s3        (s3),
		.zneg      (zneg),
		.zbus      (zbus),
		.cfg       (cfg),
		.f7_wr     (f7_wr),
		.pent_mode (pent_mode),
		.rd_be     (rd_be)
	);

	// one pager per 16 KB window
	for (genvar i = 0; i < pager_cfg_pkg::NUM_WIN; i++)
	begin : g_win
		window_pager #(.WIN(i)) u_pager
		(
			.fclk      (fclk),
			.reset     (reset),
			.s3        (s3),
			.f7_wr     (f7_wr),
			.fetch_stb (fetch_stb),
			.pager_off (pager_off),
			.in_nmi    (in_nmi),
			.dos       (dos),
			.zbus      (zbus),
			.pent_mode (pent_mode),
			.cfg       (cfg[i]),
			.map       (map[i]),
			.dos_req   (dos_req[i]),
			.ram_req   (ram_req[i])
		);
	end

endmodule

// ==== src/dos_ctrl.sv ====
`timescale 1ns/1ps

module dos_ctrl
(
	input  logic                              fclk,
	input  logic                              reset,
	input  logic                              s3,
	input  logic                              zpos,     // z80 clock rising edge
	input  logic                              zneg,     // z80 clock falling edge
	input  zbus_pkg::zbus_t                   zbus,
	input  logic [pager_cfg_pkg::NUM_WIN-1:0] dos_req,  // per window, already fetch-gated
	input  logic [pager_cfg_pkg::NUM_WIN-1:0] ram_req,  // per window, already fetch-gated
	output logic                              fetch_stb,
	output logic                              dos,
	output logic                              zclk_stall
);

	logic       m1_n_q;      // m1_n taken at zpos
	logic       mreq_n_q;    // mreq_n taken at zneg
	logic       dos_turn_on;
	logic       dos_turn_off;
	logic [2:0] stall_cnt;   // 0 idle, then 5 6 7 while stalling

	// bus level history
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			m1_n_q   <= 1'b1; // idle bus
			mreq_n_q <= 1'b1;
		end
		else if (s3)
		begin
			if (zpos)
				m1_n_q <= zbus.m1_n;
			if (zneg)
				mreq_n_q <= zbus.mreq_n;
		end
	end

	// opcode fetch start
	// mreq goes low at a zneg while m1 was seen low at the zpos before,
	// mreq high at the previous zneg makes it a single strobe per fetch
	assign fetch_stb = s3 & zneg & ~zbus.mreq_n & mreq_n_q & ~m1_n_q;

	assign dos_turn_on  = |dos_req;
	assign dos_turn_off = |ram_req;

	// dos flag
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			dos <= 1'b1; // start in dos rom
		end
		else if (s3)
		begin
			if (dos_turn_on)
				dos <= 1'b1; // turn-on wins over turn-off
			else if (dos_turn_off)
				dos <= 1'b0;
		end
	end

	// clock stall
	// the rom half changes under the running fetch,
	// hold the z80 while the new data settles
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			stall_cnt <= 3'd0;
		end
		else if (s3)
		begin
			if (dos_turn_on)
				stall_cnt <= 3'd5;
			else if (stall_cnt[2])
				stall_cnt <= stall_cnt + 3'd1; // 7 wraps to 0 and stops
		end
	end

	assign zclk_stall = dos_turn_on | stall_cnt[2];

endmodule

// ==== src/window_pager.sv ====
`timescale 1ns/1ps

module window_pager
#(
	parameter int WIN = 0 // window index, matched against a15..a14
)
(
	input  logic                      fclk,
	input  logic                      reset,
	input  logic                      s3,
	input  logic                      f7_wr,     // xxF7 write strobe from port_regs
	input  logic                      fetch_stb, // opcode fetch start from dos_ctrl
	input  logic                      pager_off, // service rom everywhere
	input  logic                      in_nmi,    // nmi handler active
	input  logic                      dos,       // current dos state
	input  zbus_pkg::zbus_t           zbus,
	input  pager_cfg_pkg::pent_mode_t pent_mode,
	output pager_cfg_pkg::win_cfg_t   cfg,       // stored settings, for xxBE
	output pager_cfg_pkg::mem_map_t   map,       // registered window map
	output logic                      dos_req,   // fetch at 3Dxx in dos rom
	output logic                      ram_req    // fetch from ram in this window
);

	logic       win_hit;   // cpu address falls in this window
	logic [7:0] sel_page;  // stored page of the current set
	logic       sel_ram;   // ramnrom of the current set
	logic       sel_7ffd;  // dos7ffd of the current set
	logic [7:0] f7_page;   // page value from an xxF7 write
	logic       f7_ram;    // ramnrom value from an xxF7 write

	assign win_hit = (zbus.addr[15:14] == 2'(WIN));

	// current set, chosen by the 7FFD rom bit
	assign sel_page = pent_mode.rom_sel ? cfg.page1 : cfg.page0;
	assign sel_ram  = cfg.ramnrom[pent_mode.rom_sel];
	assign sel_7ffd = cfg.dos7ffd[pent_mode.rom_sel];

	// xxF7 data
	// a11 set: 1 MB form, d5..d0 page with top bits forced, d6 ram, d7 dos7ffd
	// a11 clear: 4 MB form, whole byte is the page and the window is ram
	assign f7_page = zbus.addr[11] ? ~{2'b11, zbus.data[5:0]} : ~zbus.data;
	assign f7_ram  = zbus.addr[11] ? zbus.data[6] : 1'b1;

	// settings registers
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			cfg <= '0;
		end
		else if (s3 && f7_wr && win_hit)
		begin
			if (pent_mode.rom_sel)
				cfg.page1 <= f7_page;
			else
				cfg.page0 <= f7_page;
			cfg.ramnrom[pent_mode.rom_sel] <= f7_ram;
			// 4 MB form keeps dos7ffd, so 7FFD paging still works over the whole ram
			if (zbus.addr[11])
				cfg.dos7ffd[pent_mode.rom_sel] <= zbus.data[7];
		end
	end

	// map register
	// rebuilt from the live settings on every enabled edge,
	// so it trails any setting change by one enabled edge
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			map.romnram <= 1'b1;
			map.page    <= pager_cfg_pkg::RESET_PAGE;
		end
		else if (s3)
		begin
			if (pager_off)
			begin
				map.romnram <= 1'b1; // same service rom in every window
				map.page    <= 8'hFF;
			end
			else if (WIN == 0 && in_nmi)
			begin
				map.romnram <= 1'b0;
				map.page    <= pager_cfg_pkg::NMI_PAGE;
			end
			else if (WIN == 0 && pent_mode.ram0_0)
			begin
				map.romnram <= 1'b0; // pentagon ram 0 at 0000
				map.page    <= 8'h00;
			end
			else
			begin
				map.romnram <= ~sel_ram;
				if (sel_7ffd && sel_ram)
				begin
					// 7FFD ram paging, 1 MB or 128 KB wide
					if (pent_mode.mb_on)
						map.page <= {sel_page[7:6], pent_mode.page};
					else
						map.page <= {sel_page[7:3], pent_mode.page[2:0]};
				end
				else if (sel_7ffd)
					map.page <= {sel_page[7:1], dos}; // rom pair, dos picks the half
				else
					map.page <= sel_page;
			end
		end
	end

	// fetch requests for dos_ctrl
	// dos entry looks at set 1 only, the basic48 rom set
	assign dos_req = fetch_stb & win_hit
		& (zbus.addr[13:8] == zbus_pkg::DOS_TRAP_HI)
		& cfg.dos7ffd[1] & ~cfg.ramnrom[1] & pent_mode.rom_sel;

	assign ram_req = fetch_stb & win_hit & sel_ram; // any opcode from ram leaves dos

endmodule

// ==== src/port_regs.sv ====
`timescale 1ns/1ps

module port_regs
(
	input  logic                   fclk,
	input  logic                   reset,
	input  logic                   s3,
	input  logic                   zneg,
	input  zbus_pkg::zbus_t        zbus,
	input  pager_cfg_pkg::win_cfg_t cfg [pager_cfg_pkg::NUM_WIN],
	output logic                   f7_wr,     // xxF7 write strobe, all windows
	output pager_cfg_pkg::pent_mode_t pent_mode,
	output logic [7:0]             rd_be      // xxBE readback value
);

	logic io_wr;   // any i/o write, one enabled cycle at zneg
	logic wr_7ffd; // partial decode, a15=0 a1=0
	logic wr_eff7; // full 16-bit decode

	pager_cfg_pkg::win_cfg_t rd_cfg; // window picked for readback

	// i/o write strobe
	// the z80 holds iorq and wr low over several edges,
	// zneg & s3 makes it a single enabled cycle
	assign io_wr = s3 & zneg & ~zbus.iorq_n & ~zbus.wr_n;

	assign f7_wr   = io_wr & (zbus.addr[7:0] == zbus_pkg::PORT_F7_LO);
	assign wr_7ffd = io_wr & ~zbus.addr[15] & ~zbus.addr[1]; // xxF7 has a1 set, never clashes
	assign wr_eff7 = io_wr & (zbus.addr == zbus_pkg::PORT_EFF7);

	// pentagon mode register
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			pent_mode <= '0;
		end
		else if (s3)
		begin
			if (wr_7ffd)
			begin
				pent_mode.rom_sel <= zbus.data[4]; // map set select
				// page bits scattered over the byte, d4 and d3 are not page bits
				pent_mode.page    <= {zbus.data[7:5], zbus.data[2:0]};
			end
			if (wr_eff7)
			begin
				pent_mode.ram0_0 <= zbus.data[3];
				pent_mode.mb_on  <= ~zbus.data[2]; // d2 low enables 1 MB
			end
		end
	end

	// readback
	// a15..a14 pick the window like on xxF7,
	// a13..a12 pick which field comes out
	assign rd_cfg = cfg[zbus.addr[15:14]];

	always_comb
	begin
		case (zbus.addr[13:12])
			2'b00:   rd_be = rd_cfg.page0;
			2'b01:   rd_be = rd_cfg.page1;
			2'b10:   rd_be = {4'b0000, rd_cfg.dos7ffd, rd_cfg.ramnrom};
			default: rd_be = 8'h00; // unused selection reads zero
		endcase
	end

endmodule

// ==== src/pager_cfg_pkg.sv ====
package pager_cfg_pkg;

	// the z80 space is cut into four 16 KB windows
	localparam int NUM_WIN = 4;

	// what one window maps to
	typedef struct packed
	{
		logic       romnram; // 1 = rom chip, 0 = ram
		logic [7:0] page;    // physical 16 KB page
	} mem_map_t;

	// settings of one window, as written through xxF7
	// every field has two sets, index picked by the 7FFD rom bit
	typedef struct packed
	{
		logic [7:0] page0;   // page for rom_sel = 0, stored inverted from the port
		logic [7:0] page1;   // page for rom_sel = 1
		logic [1:0] ramnrom; // 1 = ram, 0 = rom
		logic [1:0] dos7ffd; // ram: take 7FFD page bits, rom: dos enters bit 0
	} win_cfg_t;

	// pentagon mode, held from 7FFD and EFF7
	typedef struct packed
	{
		logic       rom_sel; // 7FFD d4, selects the map set
		logic [5:0] page;    // 7FFD d7,d6,d5,d2,d1,d0
		logic       ram0_0;  // EFF7 d3, ram page 0 into window 0
		logic       mb_on;   // inverse of EFF7 d2, 1 MB addressing
	} pent_mode_t;

	// page constants
	// service rom sits at the top page after reset,
	// nmi handler lives in the last ram page
	localparam logic [7:0] RESET_PAGE = 8'hFF;
	localparam logic [7:0] NMI_PAGE   = 8'hFF;

endpackage

// ==== src/zbus_pkg.sv ====
package zbus_pkg;

	// one sample of the z80 bus as seen by the pager
	// all control levels are active low, as on the cpu pins
	typedef struct packed
	{
		logic [15:0] addr;   // z80 address bus
		logic [7:0]  data;   // z80 data bus, latched on port writes
		logic        mreq_n; // memory request
		logic        iorq_n; // i/o request
		logic        rd_n;   // read strobe
		logic        wr_n;   // write strobe
		logic        m1_n;   // opcode fetch cycle
	} zbus_t;

	// port addresses
	// xxF7 and xxBE are decoded on the low byte only.
	// the high byte picks the window and the form
	localparam logic [7:0]  PORT_F7_LO = 8'hF7; // window config, 4 MB or 1 MB form
	localparam logic [7:0]  PORT_BE_LO = 8'hBE; // per-window config readback
	localparam logic [15:0] PORT_EFF7  = 16'hEFF7; // pentagon ram0 / 1 MB switch

	// address bits 13..8 of the dos entry trap (3Dxx)
	localparam logic [5:0] DOS_TRAP_HI = 6'h3D;

endpackage
